//--- cache_pkg.sv
package cache_pkg;

  //////////////////////////////
  // Geometry
  //////////////////////////////

  // Data and address width
  localparam int XLEN      = 32;

  // Set index width, 16 sets
  localparam int IDX_BITS  = 4;

  // Byte offset inside one word
  localparam int OFFS_BITS = 2;

  // Tag takes the rest of the address
  localparam int TAG_BITS  = XLEN - IDX_BITS - OFFS_BITS;

  // Number of sets in the arrays
  localparam int SETS      = 1 << IDX_BITS;

  //////////////////////////////
  // Words and addresses
  //////////////////////////////

  typedef logic [XLEN-1:0] cache_word_t;

  // Address, seen as a flat word or as tag, index and offset
  typedef union packed {
    logic [XLEN-1:0] word;
    struct packed {
      logic [TAG_BITS-1:0]  tag;
      logic [IDX_BITS-1:0]  idx;
      logic [OFFS_BITS-1:0] offs;
    } f;
  } cache_adr_u;

  // One core request on its way down the pipeline
  typedef struct packed {
    logic        valid;
    logic        we;
    cache_adr_u  adr;
    cache_word_t wdata;
  } cache_req_t;

  //////////////////////////////
  // Memory bus
  //////////////////////////////

  // Request level, held until the ack pulse
  typedef struct packed {
    logic        req;
    logic        we;
    cache_word_t adr;
    cache_word_t wdata;
  } mem_req_t;

  // Ack pulse, rdata valid in the same cycle
  typedef struct packed {
    logic        ack;
    cache_word_t rdata;
  } mem_rsp_t;

  // One write into tag, valid and data arrays
  typedef struct packed {
    logic                we;
    logic [IDX_BITS-1:0] idx;
    logic [TAG_BITS-1:0] tag;
    cache_word_t         data;
  } mem_fill_t;

endpackage

//--- cache_setup.sv
`timescale 1ns/1ps

module cache_setup
  import cache_pkg::*;
(
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                stall_i,
  input  logic                flush_i,
  input  logic                req_i,
  input  logic                we_i,
  input  cache_adr_u          adr_i,
  input  cache_word_t         wdata_i,
  output cache_req_t          req_o,
  output logic [IDX_BITS-1:0] idx_o
);

  logic                valid_q;
  logic                we_q;
  cache_adr_u          adr_q;
  cache_word_t         wdata_q;
  logic                flush_dly_q;
  logic [IDX_BITS-1:0] idx_dly_q;

  //////////////////////////////
  // Request register
  //////////////////////////////

  // Flush seen one cycle late reloads the held index
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      flush_dly_q <= 1'b0;
    else
      flush_dly_q <= flush_i;
  end

  // A flush kills the request even while stalled
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      valid_q <= 1'b0;
    else if (flush_i)
      valid_q <= 1'b0;
    else if (!stall_i)
      valid_q <= req_i;
  end

  // Payload only moves with the pipe
  always_ff @(posedge clk_i)
  begin
    if (!stall_i)
    begin
      we_q    <= we_i;
      adr_q   <= adr_i;
      wdata_q <= wdata_i;
    end
  end

  assign req_o = '{valid: valid_q, we: we_q, adr: adr_q, wdata: wdata_q};

  //////////////////////////////
  // Array index
  //////////////////////////////

  // Copy of the index for the request now in hit check
  always_ff @(posedge clk_i)
  begin
    if (!stall_i || flush_dly_q)
      idx_dly_q <= adr_i.f.idx;
  end

  // Memories register the live index unless stalled
  assign idx_o = (stall_i && !flush_dly_q) ? idx_dly_q : adr_i.f.idx;

  // Held request keeps its set in the arrays for the whole stall
  a_idx_hold : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (stall_i && $past(stall_i) && req_o.valid) |-> $stable(idx_o));

endmodule

//--- cache_memory.sv
`timescale 1ns/1ps

module cache_memory
  import cache_pkg::*;
(
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic [IDX_BITS-1:0] idx_i,
  input  mem_fill_t           fill_i,
  input  logic                inv_i,
  output logic [TAG_BITS-1:0] tag_o,
  output logic                valid_o,
  output cache_word_t         data_o
);

  logic [TAG_BITS-1:0] tag_mem [SETS];
  cache_word_t         data_mem [SETS];
  logic [SETS-1:0]     valid_q;
  logic                fill_same;

  // Write and read on the same set in one cycle
  assign fill_same = fill_i.we && (fill_i.idx == idx_i);

  //////////////////////////////
  // Tag and data arrays
  //////////////////////////////

  always_ff @(posedge clk_i)
  begin
    if (fill_i.we)
    begin
      tag_mem[fill_i.idx]  <= fill_i.tag;
      data_mem[fill_i.idx] <= fill_i.data;
    end
  end

  // Registered read, write first on a collision
  always_ff @(posedge clk_i)
  begin
    if (fill_same)
    begin
      tag_o  <= fill_i.tag;
      data_o <= fill_i.data;
    end
    else
    begin
      tag_o  <= tag_mem[idx_i];
      data_o <= data_mem[idx_i];
    end
  end

  //////////////////////////////
  // Valid bits
  //////////////////////////////

  // Miss drops the victim line, a fill sets it again
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      valid_q <= '0;
    else
    begin
      if (inv_i)
        valid_q[idx_i] <= 1'b0;
      if (fill_i.we)
        valid_q[fill_i.idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      valid_o <= 1'b0;
    else if (fill_same)
      valid_o <= 1'b1;
    else if (inv_i)
      valid_o <= 1'b0;
    else
      valid_o <= valid_q[idx_i];
  end

endmodule

//--- cache_hit_check.sv
`timescale 1ns/1ps

module cache_hit_check
  import cache_pkg::*;
(
  input  logic                clk_i,
  input  logic                rst_ni,
  input  cache_req_t          req_i,
  input  logic [TAG_BITS-1:0] tag_i,
  input  logic                valid_i,
  input  cache_word_t         data_i,
  input  logic                fill_done_i,
  input  cache_word_t         fill_data_i,
  input  logic                wb_full_i,
  output logic                stall_o,
  output logic                ack_o,
  output cache_word_t         rdata_o,
  output logic                miss_o,
  output logic                wb_push_o,
  output cache_req_t          wb_req_o,
  output mem_fill_t           upd_o
);

  logic hit;
  logic rd;
  logic wr;
  logic pend_q;

  //////////////////////////////
  // Lookup
  //////////////////////////////

  assign hit = valid_i && (tag_i == req_i.adr.f.tag);
  assign rd  = req_i.valid && !req_i.we;
  assign wr  = req_i.valid && req_i.we;

  // Read miss level dropped in the cycle the refill reports back
  assign miss_o = rd && (!hit || pend_q) && !fill_done_i;

  // Refill in flight
  // keeps the stall even when a flush took the request away
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      pend_q <= 1'b0;
    else if (fill_done_i)
      pend_q <= 1'b0;
    else if (miss_o)
      pend_q <= 1'b1;
  end

  //////////////////////////////
  // Writes
  //////////////////////////////

  // Every write posts to the buffer once it has room
  assign wb_push_o = wr && !wb_full_i;
  assign wb_req_o  = req_i;

  // Only a write hit updates the arrays
  assign upd_o = '{we:   wb_push_o && hit,
                   idx:  req_i.adr.f.idx,
                   tag:  req_i.adr.f.tag,
                   data: req_i.wdata};

  //////////////////////////////
  // Core response
  //////////////////////////////

  assign stall_o = miss_o || (pend_q && !fill_done_i) || (wr && wb_full_i);

  // Read hit, refill completion or posted write
  assign ack_o = (rd && hit && !pend_q) || (rd && fill_done_i) || wb_push_o;

  // Fill word bypasses the arrays on completion
  assign rdata_o = fill_done_i ? fill_data_i : data_i;

  // No buffer push while a refill is wanted or in flight
  a_miss_push : assert property (@(posedge clk_i) disable iff (!rst_ni)
    !((miss_o || pend_q) && wb_push_o));

  // Core sees an ack only when the pipe moves on
  a_ack_stall : assert property (@(posedge clk_i) disable iff (!rst_ni)
    ack_o |-> !stall_o);

endmodule

//--- cache_refill.sv
`timescale 1ns/1ps

module cache_refill
  import cache_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        miss_i,
  input  cache_req_t  miss_req_i,
  output mem_req_t    mem_o,
  input  mem_rsp_t    mem_i,
  output mem_fill_t   fill_o,
  output logic        done_o,
  output cache_word_t data_o
);

  typedef enum logic {
    RF_IDLE,
    RF_BUSY
  } rf_state_e;

  rf_state_e   state_q;
  rf_state_e   state_d;
  logic        done_q;
  cache_adr_u  adr_q;
  cache_word_t data_q;

  //////////////////////////////
  // Refill FSM
  //////////////////////////////

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      RF_IDLE : if (miss_i) state_d = RF_BUSY;
      RF_BUSY : if (mem_i.ack) state_d = RF_IDLE;
      default : state_d = RF_IDLE;
    endcase
  end

  // done pulses in the cycle after the bus ack
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      state_q <= RF_IDLE;
      done_q  <= 1'b0;
    end
    else
    begin
      state_q <= state_d;
      done_q  <= (state_q == RF_BUSY) && mem_i.ack;
    end
  end

  // Missing address taken at start, word taken at ack
  always_ff @(posedge clk_i)
  begin
    if ((state_q == RF_IDLE) && miss_i)
      adr_q <= miss_req_i.adr;
    if ((state_q == RF_BUSY) && mem_i.ack)
      data_q <= mem_i.rdata;
  end

  // Bus read held for the whole busy state
  assign mem_o = '{req: (state_q == RF_BUSY), we: 1'b0, adr: adr_q.word, wdata: '0};

  // Word and tag go into the arrays with done
  assign fill_o = '{we: done_q, idx: adr_q.f.idx, tag: adr_q.f.tag, data: data_q};
  assign done_o = done_q;
  assign data_o = data_q;

endmodule

//--- cache_write_buffer.sv
`timescale 1ns/1ps

module cache_write_buffer
  import cache_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       push_i,
  input  cache_req_t req_i,
  output mem_req_t   mem_o,
  input  mem_rsp_t   mem_i,
  output logic       full_o
);

  logic       busy_q;
  cache_req_t ent_q;

  //////////////////////////////
  // Entry
  //////////////////////////////

  // Occupied until the bus acks, a push in the ack cycle refills it
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      busy_q <= 1'b0;
    else if (push_i)
      busy_q <= 1'b1;
    else if (mem_i.ack)
      busy_q <= 1'b0;
  end

  always_ff @(posedge clk_i)
  begin
    if (push_i)
      ent_q <= req_i;
  end

  // Draining in this cycle counts as free
  assign full_o = busy_q && !mem_i.ack;

  // Bus write straight from the entry
  assign mem_o = '{req: busy_q, we: ent_q.we, adr: ent_q.adr.word, wdata: ent_q.wdata};

  // Hit check waits for room before it posts
  a_push_full : assert property (@(posedge clk_i) disable iff (!rst_ni)
    push_i |-> !full_o);

endmodule

//--- cache_bus_arbiter.sv
`timescale 1ns/1ps

module cache_bus_arbiter
  import cache_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  input  mem_req_t wb_req_i,
  input  mem_req_t rf_req_i,
  output mem_rsp_t wb_rsp_o,
  output mem_rsp_t rf_rsp_o,
  output mem_req_t mem_o,
  input  mem_rsp_t mem_i
);

  typedef enum logic [1:0] {
    GNT_NONE,
    GNT_WB,
    GNT_RF
  } gnt_e;

  gnt_e gnt_q;
  gnt_e pick;
  gnt_e sel;

  // Fixed priority, write buffer first
  always_comb
  begin
    if (wb_req_i.req)
      pick = GNT_WB;
    else if (rf_req_i.req)
      pick = GNT_RF;
    else
      pick = GNT_NONE;
  end

  // Held grant wins over a new pick
  assign sel = (gnt_q != GNT_NONE) ? gnt_q : pick;

  // Grant lives until the ack pulse
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      gnt_q <= GNT_NONE;
    else
      gnt_q <= mem_i.ack ? GNT_NONE : sel;
  end

  //////////////////////////////
  // Bus mux and ack routing
  //////////////////////////////

  always_comb
  begin
    case (sel)
      GNT_WB  : mem_o = wb_req_i;
      GNT_RF  : mem_o = rf_req_i;
      default : mem_o = '0;
    endcase
  end

  assign wb_rsp_o = '{ack: mem_i.ack && (sel == GNT_WB), rdata: mem_i.rdata};
  assign rf_rsp_o = '{ack: mem_i.ack && (sel == GNT_RF), rdata: mem_i.rdata};

  // Bus only acks a request that one peer holds
  a_ack_idle : assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_i.ack |-> (sel != GNT_NONE));

endmodule

//--- cache_top.sv
`timescale 1ns/1ps

module cache_top
  import cache_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        req_i,
  input  logic        we_i,
  input  cache_adr_u  adr_i,
  input  cache_word_t wdata_i,
  input  logic        flush_i,
  output logic        stall_o,
  output logic        ack_o,
  output cache_word_t rdata_o,
  output mem_req_t    mem_o,
  input  mem_rsp_t    mem_i
);

  cache_req_t          s_req;
  cache_req_t          wb_req;
  logic [IDX_BITS-1:0] idx;
  logic [TAG_BITS-1:0] tag;
  logic                valid;
  cache_word_t         data;
  logic                miss;
  logic                done;
  cache_word_t         fill_data;
  logic                wb_push;
  logic                wb_full;
  mem_fill_t           upd;
  mem_fill_t           rf_fill;
  mem_fill_t           fill;
  mem_req_t            wb_mreq;
  mem_req_t            rf_mreq;
  mem_rsp_t            wb_mrsp;
  mem_rsp_t            rf_mrsp;

  //////////////////////////////
  // Pipeline
  //////////////////////////////

  cache_setup u_setup (
    .clk_i, .rst_ni, .stall_i(stall_o), .flush_i, .req_i, .we_i, .adr_i, .wdata_i,
    .req_o(s_req), .idx_o(idx)
  );

  // Refill first, the two never write in one cycle
  assign fill = rf_fill.we ? rf_fill : upd;

  // Read miss invalidates the set it is about to replace
  cache_memory u_memory (
    .clk_i, .rst_ni, .idx_i(idx), .fill_i(fill), .inv_i(miss),
    .tag_o(tag), .valid_o(valid), .data_o(data)
  );

  cache_hit_check u_hit_check (
    .clk_i, .rst_ni, .req_i(s_req), .tag_i(tag), .valid_i(valid), .data_i(data),
    .fill_done_i(done), .fill_data_i(fill_data), .wb_full_i(wb_full),
    .stall_o, .ack_o, .rdata_o, .miss_o(miss), .wb_push_o(wb_push),
    .wb_req_o(wb_req), .upd_o(upd)
  );

  //////////////////////////////
  // Bus side
  //////////////////////////////

  cache_refill u_refill (
    .clk_i, .rst_ni, .miss_i(miss), .miss_req_i(s_req), .mem_o(rf_mreq), .mem_i(rf_mrsp),
    .fill_o(rf_fill), .done_o(done), .data_o(fill_data)
  );

  cache_write_buffer u_write_buffer (
    .clk_i, .rst_ni, .push_i(wb_push), .req_i(wb_req), .mem_o(wb_mreq), .mem_i(wb_mrsp),
    .full_o(wb_full)
  );

  cache_bus_arbiter u_bus_arbiter (
    .clk_i, .rst_ni, .wb_req_i(wb_mreq), .rf_req_i(rf_mreq),
    .wb_rsp_o(wb_mrsp), .rf_rsp_o(rf_mrsp), .mem_o, .mem_i
  );

endmodule

//--- tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen
(
  output logic clk_o,
  output logic rst_n_o
);

  // 40 ns period, reset held for 4 rising edges
  initial
  begin
    clk_o   = 1'b0;
    rst_n_o = 1'b0;
    repeat (4) @(posedge clk_o);
    #5;
    rst_n_o = 1'b1;
  end

  always #20 clk_o = ~clk_o;

endmodule

//--- cache_tb.sv
`timescale 1ns/1ps

module cache_tb
  import cache_pkg::*;
();

  // Inputs change this long after the rising edge
  localparam int DRV         = 5;
  localparam int N_RAND      = 200;
  // Directed operations plus the random run
  localparam int N_OPS       = N_RAND + 30;
  localparam int CYCLE_LIMIT = N_OPS * 12 + 100;

  logic        clk;
  logic        rst_n;
  logic        req;
  logic        we;
  cache_adr_u  adr;
  cache_word_t wdata;
  logic        flush;
  logic        stall;
  logic        ack;
  cache_word_t rdata;
  mem_req_t    mem_req;
  mem_rsp_t    mem_rsp;

  logic [31:0] lfsr_state = 32'hd39a86dc;
  cache_word_t bus_mem [256];
  cache_word_t shadow [256];
  // Outstanding requests in issue order
  bit          rd_q [$];
  cache_word_t exp_q [$];
  string       test_name;
  int          cycle;
  int          ack_cycle;
  int          lat;
  // Bus transaction in progress
  logic        bus_busy;
  int          bus_wait;
  logic        bus_we;
  cache_word_t bus_adr;
  cache_word_t bus_wdata;

  tb_clock_gen u_clock_gen (.clk_o(clk), .rst_n_o(rst_n));

  cache_top dut (
    .clk_i(clk), .rst_ni(rst_n), .req_i(req), .we_i(we), .adr_i(adr), .wdata_i(wdata),
    .flush_i(flush), .stall_o(stall), .ack_o(ack), .rdata_o(rdata),
    .mem_o(mem_req), .mem_i(mem_rsp)
  );

  //////////////////////////////
  // Helpers
  //////////////////////////////

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("TEST RESULT: FAIL");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_word(input string name, input cache_word_t exp, input cache_word_t act);
    if (act !== exp)
      fail_run($sformatf("Mismatch %s: expected %h, actual %h", name, exp, act));
  endtask

  task automatic check_cycles(input string name, input int exp, input int act);
    if (act != exp)
      fail_run($sformatf("Mismatch %s: expected latency %0d, actual %0d", name, exp, act));
  endtask

  // Galois LFSR, taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    int          i;
    v = '0;
    for (i = 0; i < n; i++)
    begin
      lfsr_state = lfsr_step(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  // Start contents, every bit of the word index shows up
  function automatic cache_word_t fill_pattern(input int i);
    logic [7:0] b;
    b = i[7:0];
    return {b, ~b, b ^ 8'ha5, b + 8'h3c};
  endfunction

  // Expected read data, newest accepted write wins
  function automatic cache_word_t ref_word(input cache_word_t a);
    return shadow[a[9:2]];
  endfunction

  // One request, wait for its ack, latency counted from acceptance
  task automatic run_op(input string name, input logic w, input cache_word_t a,
                        input cache_word_t d, output int lat_o);
    int t0;
    test_name = name;
    req       = 1'b1;
    we        = w;
    adr.word  = a;
    wdata     = d;
    @(posedge clk);
    while (stall !== 1'b0)
      @(posedge clk);
    t0 = cycle;
    rd_q.push_back(!w);
    exp_q.push_back(ref_word(a));
    if (w)
      shadow[a[9:2]] = d;
    #DRV;
    req = 1'b0;
    while (rd_q.size() != 0)
    begin
      @(posedge clk);
      #DRV;
    end
    lat_o = ack_cycle - t0;
  endtask

  // No ack may show up, stall must clear again
  task automatic check_stall_free(input string name, input int n);
    int k;
    k = 0;
    while (k < n || stall !== 1'b0)
    begin
      @(posedge clk);
      if (ack !== 1'b0)
        fail_run($sformatf("Mismatch %s: expected ack_o %b, actual %b", name, 1'b0, ack));
      k++;
    end
    #DRV;
  endtask

  // Early kills the request as it enters, late kills it during its miss
  task automatic flush_op(input string name, input cache_word_t a, input bit late);
    test_name = name;
    req       = 1'b1;
    we        = 1'b0;
    adr.word  = a;
    flush     = !late;
    @(posedge clk);
    #DRV;
    req   = 1'b0;
    flush = late;
    @(posedge clk);
    #DRV;
    flush = 1'b0;
    check_stall_free(name, 10);
  endtask

  //////////////////////////////
  // Bus memory model
  //////////////////////////////

  always @(posedge clk)
  begin
    if (mem_rsp.ack)
    begin
      // Handshake done at this edge
      if (bus_we)
        bus_mem[bus_adr[9:2]] = bus_wdata;
      bus_busy = 1'b0;
      #DRV;
      mem_rsp = '0;
    end
    else if (mem_req.req)
    begin
      if (!bus_busy)
      begin
        bus_busy  = 1'b1;
        bus_wait  = rand_bits(2);
        bus_we    = mem_req.we;
        bus_adr   = mem_req.adr;
        bus_wdata = mem_req.wdata;
      end
      if (bus_wait == 0)
      begin
        #DRV;
        mem_rsp.ack   = 1'b1;
        mem_rsp.rdata = bus_mem[bus_adr[9:2]];
      end
      else
        bus_wait--;
    end
  end

  //////////////////////////////
  // Compare and timeout
  //////////////////////////////

  // Acks come back in order, writes only pop their slot
  always @(posedge clk)
  begin
    if (ack === 1'b1)
    begin
      if (rd_q.size() == 0)
        fail_run($sformatf("%s: ack_o came with no request outstanding", test_name));
      ack_cycle = cycle;
      if (rd_q.pop_front())
        check_word(test_name, exp_q.pop_front(), rdata);
      else
        void'(exp_q.pop_front());
    end
  end

  always @(posedge clk)
  begin
    cycle <= cycle + 1;
    if (cycle >= CYCLE_LIMIT)
      fail_run($sformatf("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT));
  end

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial
  begin
    int          i;
    logic        w;
    cache_word_t a;
    cache_word_t d;
    req      = 1'b0;
    we       = 1'b0;
    adr      = '0;
    wdata    = '0;
    flush    = 1'b0;
    mem_rsp  = '0;
    bus_busy = 1'b0;
    bus_wait = 0;
    for (i = 0; i < 256; i++)
    begin
      bus_mem[i] = fill_pattern(i);
      shadow[i]  = fill_pattern(i);
    end
    wait (rst_n === 1'b1);
    @(posedge clk);
    #DRV;

    // Miss fills the set, the hit answers one cycle after acceptance
    run_op("miss_hit", 1'b0, 32'h10, '0, lat);
    run_op("miss_hit", 1'b0, 32'h10, '0, lat);
    check_cycles("miss_hit", 1, lat);

    // Reads right behind writes, buffer still draining
    run_op("write_read", 1'b1, 32'h10, 32'hdeadbeef, lat);
    run_op("write_read", 1'b0, 32'h10, '0, lat);
    run_op("write_read", 1'b1, 32'h24, 32'h0badf00d, lat);
    run_op("write_read", 1'b0, 32'h24, '0, lat);
    run_op("write_read", 1'b1, 32'h10, 32'h12345678, lat);
    run_op("write_read", 1'b1, 32'h14, 32'hcafe0001, lat);
    run_op("write_read", 1'b0, 32'h14, '0, lat);
    run_op("write_read", 1'b0, 32'h10, '0, lat);

    // Same set, two tags, each read evicts the other
    for (i = 0; i < 4; i++)
    begin
      run_op("alias", 1'b0, 32'h08, '0, lat);
      run_op("alias", 1'b0, 32'h48, '0, lat);
    end

    // Killed requests give no ack, the next ones still work
    flush_op("flush_early", 32'h08, 1'b0);
    run_op("flush_early", 1'b0, 32'h08, '0, lat);
    flush_op("flush_late", 32'h88, 1'b1);
    run_op("flush_late", 1'b0, 32'h88, '0, lat);
    run_op("flush_late", 1'b0, 32'h48, '0, lat);

    // Random mix over 64 word addresses
    for (i = 0; i < N_RAND; i++)
    begin
      w = rand_bits(1);
      a = rand_bits(6) << 2;
      d = rand_bits(32);
      run_op("random", w, a, d, lat);
    end

    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

//--- flist.f
cache_pkg.sv
cache_setup.sv
cache_memory.sv
cache_hit_check.sv
cache_refill.sv
cache_write_buffer.sv
cache_bus_arbiter.sv
cache_top.sv
tb_clock_gen.sv
cache_tb.sv
